// ==== common/dcache_defines.svh ====
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// geometry, 4 ways x 64 sets x 8 words = 8 KiB
`define DC_WORDS_PER_LINE 8
`define DC_WAYS 4
`define DC_SETS 64

// address split: tag | index | word | byte
`define DC_OFFSET_BITS 5
`define DC_INDEX_BITS 6
`define DC_TAG_BITS 21
`define DC_WORD_SEL_BITS 3

`endif

// ==== common/dcache_pkg.sv ====
`default_nettype none

`include "dcache_defines.svh"

package dcache_pkg;

	typedef logic [31:0] word_t;
	typedef logic [`DC_INDEX_BITS-1:0] set_idx_t;
	typedef logic [1:0] way_idx_t;
	typedef logic [`DC_WAYS-1:0] way_mask_t;
	typedef logic [`DC_WORD_SEL_BITS-1:0] word_sel_t;
	typedef logic [2:0] plru_bits_t;

	typedef struct packed {
		logic valid;
		logic [`DC_TAG_BITS-1:0] tag;
	} tag_entry_t;

	typedef word_t [`DC_WORDS_PER_LINE-1:0] line_t;

	// processor request as held in the controller
	typedef struct packed {
		word_t adr;
		logic we;
		logic [3:0] sel;
		word_t dat;
	} cpu_req_t;

	// wishbone master side, sel is tied high at the top
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		word_t adr;
		word_t dat;
	} mem_req_t;

	typedef struct packed {
		logic en;
		set_idx_t set;
		way_mask_t mask;
		line_t line;
	} line_wr_t;

	typedef enum logic [2:0] {
		ST_SWEEP,
		ST_IDLE,
		ST_LOOKUP,
		ST_EVICT_READ,
		ST_WRITE_BACK,
		ST_REFILL,
		ST_INSTALL
	} dcache_state_t;

endpackage

`default_nettype wire

// ==== design/cache_ram.sv ====
`default_nettype none

module cache_ram #(
	parameter type T = logic [31:0],
	parameter int DEPTH = 64
) (
	input logic i_clk,
	input dcache_pkg::set_idx_t i_rd_addr,
	output T o_rd_data,
	input logic i_wr_en,
	input dcache_pkg::set_idx_t i_wr_addr,
	input T i_wr_data
);

	T r_mem [DEPTH];

	always_ff @(posedge i_clk) begin
		if (i_wr_en)
			r_mem[i_wr_addr] <= i_wr_data;
		// same-address write wins so a replay right after install sees the new line
		if (i_wr_en && i_wr_addr == i_rd_addr)
			o_rd_data <= i_wr_data;
		else
			o_rd_data <= r_mem[i_rd_addr];
	end

endmodule

`default_nettype wire

// ==== design/dcache_ctrl.sv ====
`default_nettype none

`include "dcache_defines.svh"

module dcache_ctrl (
	input logic i_clk,
	input logic i_rst,
	input logic i_cpu_cyc,
	input logic i_cpu_stb,
	input dcache_pkg::cpu_req_t i_cpu_req,
	output logic o_cpu_ack,
	input logic i_hit,
	input dcache_pkg::way_idx_t i_hit_way,
	input dcache_pkg::way_idx_t i_victim_way,
	input dcache_pkg::tag_entry_t i_victim_entry,
	input dcache_pkg::word_t i_buf_word,
	input dcache_pkg::line_t i_buf_line,
	input logic i_mem_ack,
	output dcache_pkg::mem_req_t o_mem,
	output dcache_pkg::set_idx_t o_rd_set,
	output logic [`DC_TAG_BITS-1:0] o_tag,
	output dcache_pkg::way_idx_t o_rd_way,
	output logic o_tag_wr_en,
	output dcache_pkg::set_idx_t o_tag_wr_set,
	output dcache_pkg::way_mask_t o_tag_wr_mask,
	output dcache_pkg::tag_entry_t o_tag_wr_data,
	output logic o_merge_en,
	output dcache_pkg::word_sel_t o_merge_word,
	output dcache_pkg::line_wr_t o_line_wr,
	output logic o_touch,
	output dcache_pkg::way_idx_t o_touch_way,
	output logic o_buf_load,
	output logic o_buf_fill,
	output dcache_pkg::word_sel_t o_word_sel
);
	import dcache_pkg::*;

	dcache_state_t r_state;
	set_idx_t r_sweep_cnt;
	word_sel_t r_word_cnt;
	logic r_ack;
	cpu_req_t r_req;
	way_idx_t r_way;
	logic [`DC_TAG_BITS-1:0] r_victim_tag;

	logic accept;
	logic lookup_hit;
	logic lookup_miss;
	logic install;
	logic sweep;
	logic last_word;
	set_idx_t req_set;
	set_idx_t new_set;
	logic [`DC_TAG_BITS-1:0] req_tag;
	way_idx_t wr_way;
	way_mask_t wr_mask;

	// held request is ignored in the ack cycle
	assign accept = r_state == ST_IDLE && i_cpu_cyc && i_cpu_stb && !r_ack;
	assign lookup_hit = r_state == ST_LOOKUP && i_hit;
	assign lookup_miss = r_state == ST_LOOKUP && !i_hit;
	assign install = r_state == ST_INSTALL;
	assign sweep = r_state == ST_SWEEP;
	assign last_word = r_word_cnt == word_sel_t'(`DC_WORDS_PER_LINE - 1);

	assign req_set = r_req.adr[`DC_OFFSET_BITS +: `DC_INDEX_BITS];
	assign new_set = i_cpu_req.adr[`DC_OFFSET_BITS +: `DC_INDEX_BITS];
	assign req_tag = r_req.adr[31 -: `DC_TAG_BITS];
	assign wr_way = install ? r_way : i_hit_way;
	assign wr_mask = 4'b0001 << wr_way;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_state <= ST_SWEEP;
			r_sweep_cnt <= '0;
			r_word_cnt <= '0;
			r_ack <= 1'b0;
		end else begin
			r_ack <= lookup_hit;
			case (r_state)
				ST_SWEEP: begin
					r_sweep_cnt <= r_sweep_cnt + 1'b1;
					if (r_sweep_cnt == set_idx_t'(`DC_SETS - 1))
						r_state <= ST_IDLE;
				end
				ST_IDLE: begin
					if (accept)
						r_state <= ST_LOOKUP;
				end
				ST_LOOKUP: begin
					r_word_cnt <= '0;
					if (i_hit)
						r_state <= ST_IDLE;
					else if (i_victim_entry.valid)
						r_state <= ST_EVICT_READ;
					else
						r_state <= ST_REFILL;
				end
				ST_EVICT_READ: r_state <= ST_WRITE_BACK;
				ST_WRITE_BACK: begin
					if (i_mem_ack) begin
						r_word_cnt <= r_word_cnt + 1'b1;
						if (last_word)
							r_state <= ST_REFILL;
					end
				end
				ST_REFILL: begin
					if (i_mem_ack) begin
						r_word_cnt <= r_word_cnt + 1'b1;
						if (last_word)
							r_state <= ST_INSTALL;
					end
				end
				// replay the access, it hits now
				ST_INSTALL: r_state <= ST_LOOKUP;
				default: r_state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (accept)
			r_req <= i_cpu_req;
		if (lookup_hit)
			r_way <= i_hit_way;
		if (lookup_miss) begin
			r_way <= i_victim_way;
			r_victim_tag <= i_victim_entry.tag;
		end
	end

	assign o_cpu_ack = r_ack;
	assign o_rd_set = (r_state == ST_IDLE && !r_ack) ? new_set : req_set;
	assign o_tag = req_tag;
	assign o_rd_way = (r_state == ST_LOOKUP) ? i_hit_way : r_way;

	// sweep clears all ways of one set per cycle
	assign o_tag_wr_en = sweep || install;
	assign o_tag_wr_set = sweep ? r_sweep_cnt : req_set;
	assign o_tag_wr_mask = sweep ? '1 : wr_mask;
	assign o_tag_wr_data.valid = install;
	assign o_tag_wr_data.tag = install ? req_tag : '0;

	assign o_merge_en = lookup_hit && r_req.we;
	assign o_merge_word = r_req.adr[2 +: `DC_WORD_SEL_BITS];
	assign o_line_wr.en = o_merge_en || install;
	assign o_line_wr.set = req_set;
	assign o_line_wr.mask = wr_mask;
	assign o_line_wr.line = i_buf_line;

	assign o_touch = lookup_hit || install;
	assign o_touch_way = wr_way;
	assign o_buf_load = r_state == ST_EVICT_READ;
	assign o_buf_fill = r_state == ST_REFILL && i_mem_ack;
	assign o_word_sel = r_word_cnt;

	// one word per transfer, address held until ack
	assign o_mem.cyc = r_state == ST_WRITE_BACK || r_state == ST_REFILL;
	assign o_mem.stb = o_mem.cyc;
	assign o_mem.we = r_state == ST_WRITE_BACK;
	assign o_mem.adr = {o_mem.we ? r_victim_tag : req_tag, req_set, r_word_cnt, 2'b00};
	assign o_mem.dat = i_buf_word;

endmodule

`default_nettype wire

// ==== design/dcache_top.sv ====
`default_nettype none

`include "dcache_defines.svh"

module dcache_top (
	input logic i_clk,
	input logic i_rst,
	input logic i_cpu_cyc,
	input logic i_cpu_stb,
	input logic i_cpu_we,
	input logic [3:0] i_cpu_sel,
	input logic [31:0] i_cpu_adr,
	input logic [31:0] i_cpu_dat,
	output logic o_cpu_ack,
	output logic [31:0] o_cpu_dat,
	output logic o_mem_cyc,
	output logic o_mem_stb,
	output logic o_mem_we,
	output logic [3:0] o_mem_sel,
	output logic [31:0] o_mem_adr,
	output logic [31:0] o_mem_dat,
	input logic i_mem_ack,
	input logic [31:0] i_mem_dat
);
	import dcache_pkg::*;

	cpu_req_t cpu_req;
	mem_req_t mem_req;
	set_idx_t rd_set;
	logic [`DC_TAG_BITS-1:0] tag;
	way_idx_t rd_way;
	logic tag_wr_en;
	set_idx_t tag_wr_set;
	way_mask_t tag_wr_mask;
	tag_entry_t tag_wr_data;
	logic merge_en;
	word_sel_t merge_word;
	line_wr_t line_wr;
	logic touch;
	way_idx_t touch_way;
	logic buf_load;
	logic buf_fill;
	word_sel_t word_sel;
	logic hit;
	way_idx_t hit_way;
	way_idx_t victim_way;
	tag_entry_t victim_entry;
	line_t rd_line;
	word_t buf_word;
	line_t buf_line;

	assign cpu_req = '{adr: i_cpu_adr, we: i_cpu_we, sel: i_cpu_sel, dat: i_cpu_dat};

	assign o_mem_cyc = mem_req.cyc;
	assign o_mem_stb = mem_req.stb;
	assign o_mem_we = mem_req.we;
	assign o_mem_sel = 4'b1111;
	assign o_mem_adr = mem_req.adr;
	assign o_mem_dat = mem_req.dat;

	dcache_ctrl u_ctrl (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_cpu_cyc(i_cpu_cyc),
		.i_cpu_stb(i_cpu_stb),
		.i_cpu_req(cpu_req),
		.o_cpu_ack(o_cpu_ack),
		.i_hit(hit),
		.i_hit_way(hit_way),
		.i_victim_way(victim_way),
		.i_victim_entry(victim_entry),
		.i_buf_word(buf_word),
		.i_buf_line(buf_line),
		.i_mem_ack(i_mem_ack),
		.o_mem(mem_req),
		.o_rd_set(rd_set),
		.o_tag(tag),
		.o_rd_way(rd_way),
		.o_tag_wr_en(tag_wr_en),
		.o_tag_wr_set(tag_wr_set),
		.o_tag_wr_mask(tag_wr_mask),
		.o_tag_wr_data(tag_wr_data),
		.o_merge_en(merge_en),
		.o_merge_word(merge_word),
		.o_line_wr(line_wr),
		.o_touch(touch),
		.o_touch_way(touch_way),
		.o_buf_load(buf_load),
		.o_buf_fill(buf_fill),
		.o_word_sel(word_sel)
	);

	way_lookup u_way_lookup (
		.i_clk(i_clk),
		.i_rd_set(rd_set),
		.i_tag(tag),
		.i_victim_way(victim_way),
		.i_tag_wr_en(tag_wr_en),
		.i_tag_wr_set(tag_wr_set),
		.i_tag_wr_mask(tag_wr_mask),
		.i_tag_wr_data(tag_wr_data),
		.o_hit(hit),
		.o_hit_way(hit_way),
		.o_victim_entry(victim_entry)
	);

	// processor holds sel and data until ack, so the pins feed the merge
	line_store u_line_store (
		.i_clk(i_clk),
		.i_rd_set(rd_set),
		.i_rd_way(rd_way),
		.o_line(rd_line),
		.i_wr(line_wr),
		.i_merge_en(merge_en),
		.i_merge_word(merge_word),
		.i_merge_sel(i_cpu_sel),
		.i_merge_dat(i_cpu_dat),
		.o_word(o_cpu_dat)
	);

	plru_tree u_plru (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_set(rd_set),
		.i_touch(touch),
		.i_touch_way(touch_way),
		.o_victim_way(victim_way)
	);

	line_buffer u_line_buffer (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_load(buf_load),
		.i_line(rd_line),
		.i_fill(buf_fill),
		.i_word_sel(word_sel),
		.i_fill_dat(i_mem_dat),
		.o_word(buf_word),
		.o_line(buf_line)
	);

endmodule

`default_nettype wire

// ==== design/line_buffer.sv ====
`default_nettype none

`include "dcache_defines.svh"

module line_buffer (
	input logic i_clk,
	input logic i_rst,
	input logic i_load,
	input dcache_pkg::line_t i_line,
	input logic i_fill,
	input dcache_pkg::word_sel_t i_word_sel,
	input dcache_pkg::word_t i_fill_dat,
	output dcache_pkg::word_t o_word,
	output dcache_pkg::line_t o_line
);
	import dcache_pkg::*;

	line_t r_line;
	line_t next_line;

	// victim capture and refill never overlap
	always_comb begin
		next_line = r_line;
		if (i_load) begin
			next_line = i_line;
		end else if (i_fill) begin
			for (int i = 0; i < `DC_WORDS_PER_LINE; i++) begin
				if (word_sel_t'(i) == i_word_sel)
					next_line[i] = i_fill_dat;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst)
			r_line <= '0;
		else
			r_line <= next_line;
	end

	// writeback word goes straight to the memory data bus
	assign o_word = r_line[i_word_sel];
	assign o_line = r_line;

endmodule

`default_nettype wire

// ==== design/line_store.sv ====
`default_nettype none

`include "dcache_defines.svh"

module line_store (
	input logic i_clk,
	input dcache_pkg::set_idx_t i_rd_set,
	input dcache_pkg::way_idx_t i_rd_way,
	output dcache_pkg::line_t o_line,
	input dcache_pkg::line_wr_t i_wr,
	input logic i_merge_en,
	input dcache_pkg::word_sel_t i_merge_word,
	input logic [3:0] i_merge_sel,
	input dcache_pkg::word_t i_merge_dat,
	output dcache_pkg::word_t o_word
);
	import dcache_pkg::*;

	line_t [`DC_WAYS-1:0] rd_line;
	line_t merged;
	line_t wr_line;

	for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
		cache_ram #(
			.T(line_t),
			.DEPTH(`DC_SETS)
		) u_line_ram (
			.i_clk(i_clk),
			.i_rd_addr(i_rd_set),
			.o_rd_data(rd_line[w]),
			.i_wr_en(i_wr.en && i_wr.mask[w]),
			.i_wr_addr(i_wr.set),
			.i_wr_data(wr_line)
		);
	end

	assign o_line = rd_line[i_rd_way];
	assign o_word = o_line[i_merge_word];

	// byte lanes of the write hit over the line just read
	always_comb begin
		merged = o_line;
		for (int b = 0; b < 4; b++) begin
			if (i_merge_sel[b])
				merged[i_merge_word][8*b +: 8] = i_merge_dat[8*b +: 8];
		end
	end

	assign wr_line = i_merge_en ? merged : i_wr.line;

endmodule

`default_nettype wire

// ==== design/plru_tree.sv ====
`default_nettype none

`include "dcache_defines.svh"

module plru_tree (
	input logic i_clk,
	input logic i_rst,
	input dcache_pkg::set_idx_t i_set,
	input logic i_touch,
	input dcache_pkg::way_idx_t i_touch_way,
	output dcache_pkg::way_idx_t o_victim_way
);
	import dcache_pkg::*;

	plru_bits_t r_bits [`DC_SETS];
	plru_bits_t cur_bits;
	plru_bits_t new_bits;

	assign cur_bits = r_bits[i_set];

	// b1 picks the half, b2 and b0 the way inside it
	always_comb begin
		new_bits = cur_bits;
		case (i_touch_way)
			2'd0: new_bits[1:0] = 2'b00;
			2'd1: new_bits[1:0] = 2'b01;
			2'd2: new_bits[2:1] = 2'b01;
			default: new_bits[2:1] = 2'b11;
		endcase
	end

	always_comb begin
		if (cur_bits[1])
			o_victim_way = cur_bits[0] ? 2'd0 : 2'd1;
		else
			o_victim_way = cur_bits[2] ? 2'd2 : 2'd3;
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int s = 0; s < `DC_SETS; s++)
				r_bits[s] <= '0;
		end else if (i_touch) begin
			r_bits[i_set] <= new_bits;
		end
	end

endmodule

`default_nettype wire

// ==== design/way_lookup.sv ====
`default_nettype none

`include "dcache_defines.svh"

module way_lookup (
	input logic i_clk,
	input dcache_pkg::set_idx_t i_rd_set,
	input logic [`DC_TAG_BITS-1:0] i_tag,
	input dcache_pkg::way_idx_t i_victim_way,
	input logic i_tag_wr_en,
	input dcache_pkg::set_idx_t i_tag_wr_set,
	input dcache_pkg::way_mask_t i_tag_wr_mask,
	input dcache_pkg::tag_entry_t i_tag_wr_data,
	output logic o_hit,
	output dcache_pkg::way_idx_t o_hit_way,
	output dcache_pkg::tag_entry_t o_victim_entry
);
	import dcache_pkg::*;

	tag_entry_t [`DC_WAYS-1:0] rd_entry;
	way_mask_t way_hit;

	for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
		cache_ram #(
			.T(tag_entry_t),
			.DEPTH(`DC_SETS)
		) u_tag_ram (
			.i_clk(i_clk),
			.i_rd_addr(i_rd_set),
			.o_rd_data(rd_entry[w]),
			.i_wr_en(i_tag_wr_en && i_tag_wr_mask[w]),
			.i_wr_addr(i_tag_wr_set),
			.i_wr_data(i_tag_wr_data)
		);

		assign way_hit[w] = rd_entry[w].valid && rd_entry[w].tag == i_tag;
	end

	// at most one way matches
	always_comb begin
		o_hit_way = '0;
		for (int w = 0; w < `DC_WAYS; w++) begin
			if (way_hit[w])
				o_hit_way = way_idx_t'(w);
		end
	end

	assign o_hit = |way_hit;
	assign o_victim_entry = rd_entry[i_victim_way];

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+common
common/dcache_pkg.sv
design/cache_ram.sv
design/way_lookup.sv
design/line_store.sv
design/plru_tree.sv
design/line_buffer.sv
design/dcache_ctrl.sv
design/dcache_top.sv
verif/mem_model.sv
verif/dcache_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f flist.f --top-module dcache_tb -o dcache_sim \
	&& ./obj_dir/dcache_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== verif/dcache_tb.sv ====
`default_nettype none

`include "dcache_defines.svh"

module dcache_tb;

	localparam int N_STEPS = 12;
	localparam int TIMEOUT_CYCLES = N_STEPS * 200;
	localparam int HIT_CYCLES = 2;
	localparam int DRIVE_DELAY = 1;
	localparam int MEM_WORDS = 4096;
	localparam int MEM_IDX_BITS = 12;

	// one line in set 5 for each of tags 1 to 5
	localparam logic [31:0] LINE_A = 32'h0000_08a0;
	localparam logic [31:0] LINE_B = 32'h0000_10a0;
	localparam logic [31:0] LINE_C = 32'h0000_18a0;
	localparam logic [31:0] LINE_D = 32'h0000_20a0;
	localparam logic [31:0] LINE_E = 32'h0000_28a0;

	typedef struct packed {
		logic we;
		logic [3:0] sel;
		logic [31:0] adr;
		logic [31:0] wdat;
		logic hit;
		logic wb;
		logic [31:0] wb_line;
		logic [31:0] rdat;
	} step_t;

	logic clk = 1'b0;
	logic rst;
	logic cpu_cyc;
	logic cpu_stb;
	logic cpu_we;
	logic [3:0] cpu_sel;
	logic [31:0] cpu_adr;
	logic [31:0] cpu_wdat;
	logic cpu_ack;
	logic [31:0] cpu_rdat;
	logic mem_cyc;
	logic mem_stb;
	logic mem_we;
	logic [3:0] mem_sel;
	logic [31:0] mem_adr;
	logic [31:0] mem_wdat;
	logic mem_ack;
	logic [31:0] mem_rdat;

	step_t steps [N_STEPS];
	logic [31:0] shadow [MEM_WORDS];
	int step_cnt;

	always #5 clk = ~clk;

	dcache_top DUT (
		.i_clk(clk),
		.i_rst(rst),
		.i_cpu_cyc(cpu_cyc),
		.i_cpu_stb(cpu_stb),
		.i_cpu_we(cpu_we),
		.i_cpu_sel(cpu_sel),
		.i_cpu_adr(cpu_adr),
		.i_cpu_dat(cpu_wdat),
		.o_cpu_ack(cpu_ack),
		.o_cpu_dat(cpu_rdat),
		.o_mem_cyc(mem_cyc),
		.o_mem_stb(mem_stb),
		.o_mem_we(mem_we),
		.o_mem_sel(mem_sel),
		.o_mem_adr(mem_adr),
		.o_mem_dat(mem_wdat),
		.i_mem_ack(mem_ack),
		.i_mem_dat(mem_rdat)
	);

	mem_model #(
		.MEM_WORDS(MEM_WORDS)
	) u_mem (
		.i_clk(clk),
		.i_rst(rst),
		.i_cyc(mem_cyc),
		.i_stb(mem_stb),
		.i_we(mem_we),
		.i_sel(mem_sel),
		.i_adr(mem_adr),
		.i_dat(mem_wdat),
		.o_ack(mem_ack),
		.o_dat(mem_rdat)
	);

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Some tests failed");
		$fatal(1, "run stopped at the first failure");
	endtask

	function automatic logic [31:0] line_base(input logic [31:0] adr);
		return {adr[31:`DC_OFFSET_BITS], {`DC_OFFSET_BITS{1'b0}}};
	endfunction

	// applies a write to the shadow memory, reads take their value from it
	task automatic add_step(input logic we, input logic [3:0] sel, input logic [31:0] adr,
		input logic [31:0] wdat, input logic hit, input logic wb, input logic [31:0] wb_line);
		logic [31:0] mask;
		logic [MEM_IDX_BITS-1:0] w;
		w = adr[MEM_IDX_BITS+1:2];
		for (int b = 0; b < 4; b++)
			mask[8*b +: 8] = {8{sel[b]}};
		if (we)
			shadow[w] = (shadow[w] & ~mask) | (wdat & mask);
		steps[step_cnt] = '{we: we, sel: sel, adr: adr, wdat: wdat, hit: hit, wb: wb,
			wb_line: wb_line, rdat: we ? 32'h0 : shadow[w]};
		step_cnt++;
	endtask

	task automatic build_table();
		for (int i = 0; i < MEM_WORDS; i++)
			shadow[i] = u_mem.r_mem[i];
		step_cnt = 0;
		// tree bits start at 000, so the fills land in ways 3, 1, 2, 0
		add_step(1'b0, 4'hf, LINE_A, 32'h0, 1'b0, 1'b0, 32'h0);
		add_step(1'b1, 4'b0101, LINE_A + 4, 32'hdead_beef, 1'b1, 1'b0, 32'h0);
		add_step(1'b0, 4'hf, LINE_A + 4, 32'h0, 1'b1, 1'b0, 32'h0);
		add_step(1'b0, 4'hf, LINE_A + 4, 32'h0, 1'b1, 1'b0, 32'h0);
		add_step(1'b0, 4'hf, LINE_B + 8, 32'h0, 1'b0, 1'b0, 32'h0);
		add_step(1'b1, 4'b1000, LINE_C + 12, 32'h1234_5678, 1'b0, 1'b0, 32'h0);
		add_step(1'b0, 4'hf, LINE_D + 16, 32'h0, 1'b0, 1'b0, 32'h0);
		// bits back at 000, way 3 (A) goes, then 110 picks way 1 (B)
		add_step(1'b0, 4'hf, LINE_E, 32'h0, 1'b0, 1'b1, LINE_A);
		add_step(1'b0, 4'hf, LINE_A + 4, 32'h0, 1'b0, 1'b1, LINE_B);
		add_step(1'b0, 4'hf, LINE_C + 12, 32'h0, 1'b1, 1'b0, 32'h0);
		// hit on way 2 gives 011, so way 0 (D), then 000 gives way 3 (E)
		add_step(1'b0, 4'hf, LINE_B + 8, 32'h0, 1'b0, 1'b1, LINE_D);
		add_step(1'b0, 4'hf, LINE_D + 16, 32'h0, 1'b0, 1'b1, LINE_E);
	endtask

	// memory transfers of one request all belong to one line and cover it
	task automatic check_burst(input logic wr, input int first, input int last,
		input int exp_cnt, input logic [31:0] line);
		logic [31:0] a;
		logic [`DC_WORDS_PER_LINE-1:0] seen;
		seen = '0;
		assert (last - first == exp_cnt) else
			fail_run($sformatf("error at %0t: %0d memory %s, expected %0d", $time,
				last - first, wr ? "writes" : "reads", exp_cnt));
		for (int k = first; k < last; k++) begin
			a = wr ? u_mem.wr_log[k] : u_mem.rd_log[k];
			assert (line_base(a) == line) else
				fail_run($sformatf("error at %0t: memory %s at %h, expected line %h",
					$time, wr ? "write" : "read", a, line));
			seen[a[4:2]] = 1'b1;
		end
		assert (exp_cnt == 0 || &seen) else
			fail_run($sformatf("error at %0t: line %h not covered, words seen %b",
				$time, line, seen));
	endtask

	task automatic run_step(input int n, input step_t s);
		int cycles;
		int rd0;
		int wr0;
		rd0 = u_mem.rd_count;
		wr0 = u_mem.wr_count;
		cpu_cyc = 1'b1;
		cpu_stb = 1'b1;
		cpu_we = s.we;
		cpu_sel = s.sel;
		cpu_adr = s.adr;
		cpu_wdat = s.wdat;
		cycles = 0;
		do begin
			@(posedge clk);
			#DRIVE_DELAY;
			cycles++;
			// every memory transfer moves a whole word
			assert (!mem_stb || mem_sel == 4'hf) else
				fail_run($sformatf("error at %0t: step %0d memory sel %b, expected 1111",
					$time, n, mem_sel));
		end while (!cpu_ack);
		cpu_cyc = 1'b0;
		cpu_stb = 1'b0;
		assert (s.we || cpu_rdat == s.rdat) else
			fail_run($sformatf("error at %0t: step %0d read %h returned %h, expected %h",
				$time, n, s.adr, cpu_rdat, s.rdat));
		assert (!s.hit || cycles == HIT_CYCLES) else
			fail_run($sformatf("error at %0t: step %0d hit took %0d cycles, expected %0d",
				$time, n, cycles, HIT_CYCLES));
		check_burst(1'b0, rd0, u_mem.rd_count, s.hit ? 0 : `DC_WORDS_PER_LINE,
			line_base(s.adr));
		check_burst(1'b1, wr0, u_mem.wr_count, s.wb ? `DC_WORDS_PER_LINE : 0, s.wb_line);
		@(posedge clk);
		#DRIVE_DELAY;
		assert (!cpu_ack) else
			fail_run($sformatf("error at %0t: step %0d ack held for more than one cycle",
				$time, n));
	endtask

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		fail_run($sformatf("timeout: the run did not finish within %0d cycles",
			TIMEOUT_CYCLES));
	end

	initial begin
		rst = 1'b1;
		cpu_cyc = 1'b0;
		cpu_stb = 1'b0;
		cpu_we = 1'b0;
		cpu_sel = 4'h0;
		cpu_adr = 32'h0;
		cpu_wdat = 32'h0;
		step_cnt = 0;
		repeat (16) @(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;
		build_table();
		// first request waits out the invalidation sweep
		for (int i = 0; i < N_STEPS; i++)
			run_step(i, steps[i]);
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/mem_model.sv ====
`default_nettype none

module mem_model #(
	parameter int MEM_WORDS = 4096,
	parameter int LOG_DEPTH = 256
) (
	input logic i_clk,
	input logic i_rst,
	input logic i_cyc,
	input logic i_stb,
	input logic i_we,
	input logic [3:0] i_sel,
	input logic [31:0] i_adr,
	input logic [31:0] i_dat,
	output logic o_ack,
	output logic [31:0] o_dat
);

	localparam int IDX_BITS = $clog2(MEM_WORDS);

	logic [31:0] r_mem [MEM_WORDS];
	// every accepted transfer address, in order
	logic [31:0] rd_log [LOG_DEPTH];
	logic [31:0] wr_log [LOG_DEPTH];
	int rd_count;
	int wr_count;
	integer seed;
	logic r_busy;
	logic [1:0] r_wait;
	logic [1:0] delay;
	logic [IDX_BITS-1:0] idx;

	assign idx = i_adr[IDX_BITS+1:2];

	// mixes every bit of the byte address
	function automatic logic [31:0] fill_word(input int i);
		logic [31:0] a;
		a = 32'(i) << 2;
		return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
	endfunction

	initial seed = 32'h7a58_1dc1;

	always @(posedge i_clk) begin
		if (i_rst) begin
			o_ack <= 1'b0;
			o_dat <= '0;
			r_busy <= 1'b0;
			r_wait <= '0;
			rd_count <= 0;
			wr_count <= 0;
			for (int i = 0; i < MEM_WORDS; i++)
				r_mem[i] <= fill_word(i);
		end else begin
			o_ack <= 1'b0;
			// a request seen with ack high is the one that just ended
			if (i_cyc && i_stb && !o_ack) begin
				if (r_busy)
					delay = r_wait;
				else
					delay = 2'($unsigned($random(seed)) % 4);
				if (delay == 2'd0) begin
					o_ack <= 1'b1;
					r_busy <= 1'b0;
					if (i_we) begin
						for (int b = 0; b < 4; b++) begin
							if (i_sel[b])
								r_mem[idx][8*b +: 8] <= i_dat[8*b +: 8];
						end
						if (wr_count < LOG_DEPTH)
							wr_log[wr_count] <= i_adr;
						wr_count <= wr_count + 1;
					end else begin
						o_dat <= r_mem[idx];
						if (rd_count < LOG_DEPTH)
							rd_log[rd_count] <= i_adr;
						rd_count <= rd_count + 1;
					end
				end else begin
					r_busy <= 1'b1;
					r_wait <= delay - 2'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire
